// File: design/tcb_pkg.sv
/*
 * Shared definitions for the tightly coupled bus interconnect.
 * Holds the bus widths, the opcode and status encodings and the
 * packed request and response structs used on every bus port.
 * Modules import this package inside their body and use scoped
 * names in their port lists.
 */

package tcb_pkg;

    ////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////

    // word address, not byte address
    localparam int unsigned TCB_ADR_W = 16;
    // data word
    localparam int unsigned TCB_DAT_W = 32;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // request opcode
    typedef enum logic {
        TCB_READ  = 1'b0,
        TCB_WRITE = 1'b1
    } tcb_op_e;

    // response status
    typedef enum logic {
        TCB_OK  = 1'b0,
        TCB_ERR = 1'b1
    } tcb_sts_e;

    ////////////////////////////////////////
    // payload structs
    ////////////////////////////////////////

    // request, 49 bits
    typedef struct packed {
        tcb_op_e              op;
        logic [TCB_ADR_W-1:0] adr;
        // write data, ignored on read
        logic [TCB_DAT_W-1:0] wdt;
    } tcb_req_t;

    // response, 33 bits
    typedef struct packed {
        // zero on write or error
        logic [TCB_DAT_W-1:0] rdt;
        tcb_sts_e             sts;
    } tcb_rsp_t;

endpackage

// File: design/tcb_req_queue.sv
/*
 * Request FIFO between the external manager port and the interconnect.
 * Circular buffer with read/write pointers and an occupancy count.
 * Input ready is high while not full; output valid is high while not
 * empty. The output comes from storage, so a request pushed into an
 * empty queue shows up one cycle later.
 */

module tcb_req_queue #(
    parameter int unsigned QUEUE_DEPTH = 4
)(
    input  logic              sub,
    input  logic              rst_n,
    // input side, from external manager
    input  logic              in_vld,
    input  tcb_pkg::tcb_req_t in_req,
    output logic              in_rdy,
    // output side, towards demultiplexer
    output logic              out_vld,
    output tcb_pkg::tcb_req_t out_req,
    input  logic              out_rdy
);

    import tcb_pkg::*;

    // pointer and count widths
    localparam int unsigned PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(QUEUE_DEPTH + 1);

    ////////////////////////////////////////
    // local signals
    ////////////////////////////////////////

    // entry storage
    tcb_req_t         mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] cnt;

    // handshakes on both sides
    logic             push;
    logic             pop;

    ////////////////////////////////////////
    // status and handshake
    ////////////////////////////////////////

    assign in_rdy  = (cnt != CNT_W'(QUEUE_DEPTH));
    assign out_vld = (cnt != '0);

    assign push = in_vld & in_rdy;
    assign pop  = out_vld & out_rdy;

    // head entry straight from storage
    assign out_req = mem[rd_ptr];

    ////////////////////////////////////////
    // pointers and count
    ////////////////////////////////////////

    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (push) begin
                // wrap at depth, depth need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave count as is
            if (push && !pop) begin
                cnt <= cnt + 1'b1;
            end else if (pop && !push) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // storage write, payload only
    always_ff @(posedge sub) begin
        if (push) begin
            mem[wr_ptr] <= in_req;
        end
    end

endmodule

// File: design/tcb_addr_decoder.sv
/*
 * Address decoder for the interconnect.
 * Splits a word address into the target port index and the offset
 * inside that port's region. Bits above the port field are ignored,
 * so the address space wraps every IFN regions.
 */

module tcb_addr_decoder #(
    // IFN must be a power of two, at least 2
    parameter  int unsigned IFN         = 4,
    parameter  int unsigned REGION_BITS = 6,
    localparam int unsigned IFL         = $clog2(IFN)
)(
    input  logic [tcb_pkg::TCB_ADR_W-1:0] adr,
    // target port index
    output logic [IFL-1:0]                sel,
    // word offset inside the region
    output logic [REGION_BITS-1:0]        offset
);

    ////////////////////////////////////////
    // field split
    ////////////////////////////////////////

    // port field sits directly above the region offset
    assign sel    = adr[REGION_BITS +: IFL];

    // low bits go to the subordinate as its local address
    assign offset = adr[REGION_BITS-1:0];

endmodule

// File: design/tcb_demultiplexer.sv
/*
 * Bus demultiplexer, one subordinate port towards IFN manager ports.
 * The request goes to the port chosen by sel, ready is muxed from
 * that port by the live select. The select is registered at each
 * transfer and used one cycle later to pick the response, together
 * with the rsp_vld strobe.
 */

module tcb_demultiplexer #(
    parameter  int unsigned IFN = 4,
    localparam int unsigned IFL = $clog2(IFN)
)(
    input  logic              sub,
    input  logic              rst_n,
    // port select from decoder
    input  logic [IFL-1:0]    sel,
    // upstream side, request queue connects here
    input  logic              sub_vld,
    input  tcb_pkg::tcb_req_t sub_req,
    output logic              sub_rdy,
    output logic              rsp_vld,
    output tcb_pkg::tcb_rsp_t rsp,
    // downstream ports, subordinates connect here
    output logic              man_vld [IFN],
    output tcb_pkg::tcb_req_t man_req [IFN],
    input  logic              man_rdy [IFN],
    input  tcb_pkg::tcb_rsp_t man_rsp [IFN]
);

    ////////////////////////////////////////
    // control
    ////////////////////////////////////////

    // transfer on upstream side
    logic           trn;
    // select held for the response cycle
    logic [IFL-1:0] man_sel;

    assign trn = sub_vld & sub_rdy;

    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            man_sel <= '0;
            rsp_vld <= 1'b0;
        end else begin
            // strobe lasts exactly one cycle per transfer
            rsp_vld <= trn;
            if (trn) begin
                man_sel <= sel;
            end
        end
    end

    ////////////////////////////////////////
    // request
    ////////////////////////////////////////

    // only the selected port sees valid
    for (genvar i = 0; i < IFN; i++) begin : gen_req
        assign man_vld[i] = (sel == IFL'(i)) ? sub_vld : 1'b0;
        assign man_req[i] = (sel == IFL'(i)) ? sub_req : '0;
    end

    ////////////////////////////////////////
    // response
    ////////////////////////////////////////

    // ready follows the current select
    assign sub_rdy = man_rdy[sel];

    // response follows the select from the transfer cycle
    assign rsp = man_rsp[man_sel];

endmodule

// File: design/tcb_mem_sub.sv
/*
 * Memory subordinate on one interconnect port.
 * MEM_DEPTH words, cleared at reset, addressed by the region offset.
 * The response is registered, valid one cycle after the transfer.
 * Offsets past MEM_DEPTH answer with an error and leave memory alone.
 * After each accepted write, rdy drops for one cycle.
 */

module tcb_mem_sub #(
    // MEM_DEPTH must not exceed 2**REGION_BITS
    parameter int unsigned MEM_DEPTH   = 48,
    parameter int unsigned REGION_BITS = 6
)(
    input  logic              sub,
    input  logic              rst_n,
    input  logic              vld,
    input  tcb_pkg::tcb_req_t req,
    output logic              rdy,
    output tcb_pkg::tcb_rsp_t rsp
);

    import tcb_pkg::*;

    localparam int unsigned IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    // write recovery states
    typedef enum logic {
        MEM_IDLE,
        MEM_RECOVER
    } mem_state_e;

    ////////////////////////////////////////
    // local signals
    ////////////////////////////////////////

    logic [TCB_DAT_W-1:0]   mem [MEM_DEPTH];
    mem_state_e             state;
    logic                   trn;
    logic [REGION_BITS-1:0] offset;
    logic                   in_range;
    logic [IDX_W-1:0]       idx;

    assign trn      = vld & rdy;
    assign offset   = req.adr[REGION_BITS-1:0];
    // MEM_DEPTH may equal the full region size
    assign in_range = ({1'b0, offset} < (REGION_BITS + 1)'(MEM_DEPTH));
    // only meaningful when in range
    assign idx      = IDX_W'(offset);

    // back-pressure during recovery
    assign rdy = (state == MEM_IDLE);

    ////////////////////////////////////////
    // write recovery FSM
    ////////////////////////////////////////

    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            state <= MEM_IDLE;
        end else if (trn && req.op == TCB_WRITE) begin
            state <= MEM_RECOVER;
        end else begin
            state <= MEM_IDLE;
        end
    end

    ////////////////////////////////////////
    // memory array
    ////////////////////////////////////////

    always_ff @(posedge sub or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (trn && in_range && req.op == TCB_WRITE) begin
            mem[idx] <= req.wdt;
        end
    end

    // response register
    always_ff @(posedge sub) begin
        if (trn) begin
            if (!in_range) begin
                rsp.rdt <= '0;
                rsp.sts <= TCB_ERR;
            end else begin
                // writes answer with zero data
                rsp.rdt <= (req.op == TCB_READ) ? mem[idx] : '0;
                rsp.sts <= TCB_OK;
            end
        end
    end

endmodule

// File: design/tcb_interconnect_top.sv
/*
 * Top level of the bus interconnect.
 * External manager -> request FIFO -> address decoder and demultiplexer
 * -> IFN memory subordinates. Responses return in request order,
 * marked by rsp_vld, with no ready on the response side.
 */

module tcb_interconnect_top #(
    parameter  int unsigned IFN         = 4,
    parameter  int unsigned REGION_BITS = 6,
    parameter  int unsigned MEM_DEPTH   = 48,
    parameter  int unsigned QUEUE_DEPTH = 4,
    localparam int unsigned IFL         = $clog2(IFN)
)(
    input  logic              sub,
    input  logic              rst_n,
    input  logic              req_vld,
    input  tcb_pkg::tcb_req_t req,
    output logic              req_rdy,
    output logic              rsp_vld,
    output tcb_pkg::tcb_rsp_t rsp
);

    import tcb_pkg::*;

    ////////////////////////////////////////
    // local signals
    ////////////////////////////////////////

    // queue head
    logic                   q_vld;
    tcb_req_t               q_req;
    logic                   q_rdy;

    // decoder outputs
    logic [IFL-1:0]         sel;
    logic [REGION_BITS-1:0] offset;

    // head with local address
    tcb_req_t               dmx_req;

    // per-port buses
    logic                   port_vld [IFN];
    tcb_req_t               port_req [IFN];
    logic                   port_rdy [IFN];
    tcb_rsp_t               port_rsp [IFN];

    ////////////////////////////////////////
    // request path
    ////////////////////////////////////////

    tcb_req_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .sub     (sub),
        .rst_n   (rst_n),
        .in_vld  (req_vld),
        .in_req  (req),
        .in_rdy  (req_rdy),
        .out_vld (q_vld),
        .out_req (q_req),
        .out_rdy (q_rdy)
    );

    tcb_addr_decoder #(
        .IFN         (IFN),
        .REGION_BITS (REGION_BITS)
    ) u_decoder (
        .adr    (q_req.adr),
        .sel    (sel),
        .offset (offset)
    );

    // subordinates only see the offset
    assign dmx_req.op  = q_req.op;
    assign dmx_req.adr = {{(TCB_ADR_W-REGION_BITS){1'b0}}, offset};
    assign dmx_req.wdt = q_req.wdt;

    tcb_demultiplexer #(
        .IFN (IFN)
    ) u_demux (
        .sub     (sub),
        .rst_n   (rst_n),
        .sel     (sel),
        .sub_vld (q_vld),
        .sub_req (dmx_req),
        .sub_rdy (q_rdy),
        .rsp_vld (rsp_vld),
        .rsp     (rsp),
        .man_vld (port_vld),
        .man_req (port_req),
        .man_rdy (port_rdy),
        .man_rsp (port_rsp)
    );

    ////////////////////////////////////////
    // subordinates
    ////////////////////////////////////////

    for (genvar i = 0; i < IFN; i++) begin : gen_sub
        tcb_mem_sub #(
            .MEM_DEPTH   (MEM_DEPTH),
            .REGION_BITS (REGION_BITS)
        ) u_mem (
            .sub   (sub),
            .rst_n (rst_n),
            .vld   (port_vld[i]),
            .req   (port_req[i]),
            .rdy   (port_rdy[i]),
            .rsp   (port_rsp[i])
        );
    end

endmodule

// File: test/tb_clock_gen.sv
/*
 * Clock and reset source for the interconnect testbench.
 * Drives sub with a period of 20 and holds rst_n low for the
 * first four rising edges, releasing it just after the fourth.
 */

module tb_clock_gen #(
    parameter int unsigned PERIOD       = 20,
    parameter int unsigned RESET_CYCLES = 4
)(
    output logic sub,
    output logic rst_n
);

    // free running clock
    initial begin
        sub = 1'b0;
        forever #(PERIOD / 2) sub = ~sub;
    end

    // release shortly after an edge, away from sampling
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sub);
        #1 rst_n = 1'b1;
    end

endmodule

// File: test/tb_tcb_interconnect.sv
/*
 * Directed testbench for the interconnect top level.
 * A reference memory predicts every response at issue time; the
 * predictions wait in a queue and are compared in order as rsp_vld
 * strobes arrive. Inputs change 2 units after the rising edge,
 * outputs are sampled on the falling edge.
 */

module tb_tcb_interconnect;

    import tcb_pkg::*;

    localparam int unsigned IFN         = 4;
    localparam int unsigned REGION_BITS = 6;
    localparam int unsigned MEM_DEPTH   = 48;
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned IFL         = $clog2(IFN);

    // request counts per test, used for the watchdog limit
    localparam int unsigned WR_PER_PORT = 3;
    localparam int unsigned BURST_LEN   = 16;
    localparam int unsigned NUM_REQ     = IFN + 2 * IFN * WR_PER_PORT + 2 * IFN + 4 + 5
                                          + BURST_LEN;
    localparam int unsigned MAX_CYCLES  = 20 * NUM_REQ + 100;

    logic     sub;
    logic     rst_n;
    logic     req_vld;
    tcb_req_t req;
    logic     req_rdy;
    logic     rsp_vld;
    tcb_rsp_t rsp;

    // reference model state
    logic [TCB_DAT_W-1:0] ref_mem [IFN << REGION_BITS];
    tcb_rsp_t             exp_q [$];
    tcb_rsp_t             exp_rsp;

    string cur_test;
    int    errors;
    int    test_err0;
    int    n_tests;
    int    n_req;
    int    n_rsp;
    int    cycles;
    logic  stall_seen;

    tb_clock_gen #(
        .PERIOD       (20),
        .RESET_CYCLES (4)
    ) u_clk (
        .sub   (sub),
        .rst_n (rst_n)
    );

    tcb_interconnect_top #(
        .IFN         (IFN),
        .REGION_BITS (REGION_BITS),
        .MEM_DEPTH   (MEM_DEPTH),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) UUT (
        .sub     (sub),
        .rst_n   (rst_n),
        .req_vld (req_vld),
        .req     (req),
        .req_rdy (req_rdy),
        .rsp_vld (rsp_vld),
        .rsp     (rsp)
    );

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    // port base plus offset, high bits left zero
    function automatic logic [TCB_ADR_W-1:0] make_adr(input int port, input int off);
        return TCB_ADR_W'((port << REGION_BITS) + off);
    endfunction

    // expected response, updates the model on in-range writes
    function automatic tcb_rsp_t predict_rsp(input tcb_op_e op,
                                             input logic [TCB_ADR_W-1:0] adr,
                                             input logic [TCB_DAT_W-1:0] wdt);
        tcb_rsp_t r;
        int       idx;
        int       off;
        // bits above the port field wrap away
        idx   = int'(adr[REGION_BITS+IFL-1:0]);
        off   = int'(adr[REGION_BITS-1:0]);
        r.rdt = '0;
        if (off >= MEM_DEPTH) begin
            r.sts = TCB_ERR;
        end else begin
            r.sts = TCB_OK;
            if (op == TCB_WRITE) begin
                ref_mem[idx] = wdt;
            end else begin
                r.rdt = ref_mem[idx];
            end
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // bus driving
    ////////////////////////////////////////

    // offer one request, return 2 units after the accepting edge with req_vld still high
    task automatic send(input tcb_op_e op, input logic [TCB_ADR_W-1:0] adr,
                        input logic [TCB_DAT_W-1:0] wdt);
        req_vld = 1'b1;
        req.op  = op;
        req.adr = adr;
        req.wdt = wdt;
        @(negedge sub);
        while (!req_rdy) begin
            stall_seen = 1'b1;
            @(negedge sub);
        end
        exp_q.push_back(predict_rsp(op, adr, wdt));
        n_req++;
        @(posedge sub);
        #2;
    endtask

    task automatic idle();
        req_vld = 1'b0;
        req     = '0;
    endtask

    // wait until every expected response has come back
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge sub);
        end
        @(posedge sub);
        #2;
    endtask

    task automatic begin_test(input string name);
        cur_test   = name;
        test_err0  = errors;
        stall_seen = 1'b0;
    endtask

    task automatic end_test();
        idle();
        drain();
        n_tests++;
        if (errors == test_err0) begin
            $display("test %-16s : ok", cur_test);
        end else begin
            $display("test %-16s : %0d errors", cur_test, errors - test_err0);
        end
    endtask

    ////////////////////////////////////////
    // response checker
    ////////////////////////////////////////

    always @(negedge sub) begin
        if (rst_n && rsp_vld) begin
            if (exp_q.size() == 0) begin
                $display("ERROR %s: response arrived with no request outstanding", cur_test);
                errors++;
            end else begin
                exp_rsp = exp_q.pop_front();
                n_rsp++;
                if (rsp !== exp_rsp) begin
                    $display("MISMATCH %s: expected rdt=%08h sts=%0d, actual rdt=%08h sts=%0d",
                             cur_test, exp_rsp.rdt, exp_rsp.sts, rsp.rdt, rsp.sts);
                    errors++;
                end
            end
        end
        // what is left unanswered is what still waits in the queue
        if (rst_n && req_vld && !req_rdy && exp_q.size() < QUEUE_DEPTH) begin
            $display("ERROR %s: req_rdy low with only %0d requests waiting",
                     cur_test, exp_q.size());
            errors++;
        end
    end

    // watchdog
    initial begin : watchdog
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge sub);
            cycles++;
        end
        $display("ERROR: run timed out after %0d cycles", MAX_CYCLES);
        $display("Regression failed");
        $finish;
    end

    ////////////////////////////////////////
    // tests
    ////////////////////////////////////////

    task automatic test_reset_state();
        begin_test("reset_state");
        if (req_rdy !== 1'b1 || rsp_vld !== 1'b0) begin
            $display("MISMATCH %s: expected req_rdy=1 rsp_vld=0, actual req_rdy=%b rsp_vld=%b",
                     cur_test, req_rdy, rsp_vld);
            errors++;
        end
        // cleared memory on every port
        for (int p = 0; p < IFN; p++) begin
            send(TCB_READ, make_adr(p, 0), '0);
        end
        end_test();
    endtask

    task automatic test_write_read();
        int offs [IFN*WR_PER_PORT];
        begin_test("write_read");
        for (int i = 0; i < IFN * WR_PER_PORT; i++) begin
            offs[i] = int'($urandom % MEM_DEPTH);
            send(TCB_WRITE, make_adr(i / WR_PER_PORT, offs[i]), $urandom);
        end
        for (int i = 0; i < IFN * WR_PER_PORT; i++) begin
            send(TCB_READ, make_adr(i / WR_PER_PORT, offs[i]), '0);
        end
        end_test();
    endtask

    task automatic test_isolation_wrap();
        int                   off;
        logic [TCB_ADR_W-1:0] hi;
        begin_test("isolation_wrap");
        // same offset, different data per port
        off = int'($urandom % MEM_DEPTH);
        for (int p = 0; p < IFN; p++) begin
            send(TCB_WRITE, make_adr(p, off), $urandom);
        end
        for (int p = 0; p < IFN; p++) begin
            send(TCB_READ, make_adr(p, off), '0);
        end
        // random bits above the port field, top bit forced
        hi = TCB_ADR_W'($urandom) & ~TCB_ADR_W'((1 << (REGION_BITS + IFL)) - 1);
        hi[TCB_ADR_W-1] = 1'b1;
        off = int'($urandom % MEM_DEPTH);
        send(TCB_WRITE, hi | make_adr(2, off), $urandom);
        send(TCB_READ, make_adr(2, off), '0);
        send(TCB_WRITE, make_adr(3, off), $urandom);
        send(TCB_READ, hi | make_adr(3, off), '0);
        end_test();
    endtask

    task automatic test_out_of_range();
        int bad;
        int p;
        begin_test("out_of_range");
        p   = int'($urandom % IFN);
        bad = MEM_DEPTH + int'($urandom % ((1 << REGION_BITS) - MEM_DEPTH));
        // known contents below the limit
        send(TCB_WRITE, make_adr(p, bad - MEM_DEPTH), $urandom);
        send(TCB_WRITE, make_adr(p, bad), $urandom);
        send(TCB_READ, make_adr(p, bad), '0);
        // in-range words must be untouched
        send(TCB_READ, make_adr(p, bad - MEM_DEPTH), '0);
        send(TCB_READ, make_adr(p, MEM_DEPTH - 1), '0);
        end_test();
    endtask

    task automatic test_burst_order();
        int ports [BURST_LEN/2];
        int offs  [BURST_LEN/2];
        int p0;
        begin_test("burst_order");
        p0 = int'($urandom % IFN);
        // same-port write runs stall on write recovery
        for (int i = 0; i < BURST_LEN / 2; i++) begin
            ports[i] = (p0 + i / 4) % IFN;
            offs[i]  = int'($urandom % MEM_DEPTH);
            send(TCB_WRITE, make_adr(ports[i], offs[i]), $urandom);
        end
        // reads in reverse, crossing ports
        for (int i = BURST_LEN / 2 - 1; i >= 0; i--) begin
            send(TCB_READ, make_adr(ports[i], offs[i]), '0);
        end
        if (!stall_seen) begin
            $display("ERROR %s: req_rdy never fell during the burst", cur_test);
            errors++;
        end
        end_test();
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        req_vld  = 1'b0;
        req      = '0;
        errors   = 0;
        n_tests  = 0;
        n_req    = 0;
        n_rsp    = 0;
        cur_test = "none";
        void'($urandom(32'h6fa2));
        for (int i = 0; i < (IFN << REGION_BITS); i++) begin
            ref_mem[i] = '0;
        end

        @(posedge rst_n);
        @(posedge sub);
        #2;

        test_reset_state();
        test_write_read();
        test_isolation_wrap();
        test_out_of_range();
        test_burst_order();

        $display("summary: tests=%0d requests=%0d responses=%0d errors=%0d",
                 n_tests, n_req, n_rsp, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: tcb_interconnect_top.f
design/tcb_pkg.sv
design/tcb_req_queue.sv
design/tcb_addr_decoder.sv
design/tcb_demultiplexer.sv
design/tcb_mem_sub.sv
design/tcb_interconnect_top.sv
test/tb_clock_gen.sv
test/tb_tcb_interconnect.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the interconnect testbench with Verilator.
# Exit status is nonzero if the build fails or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_tcb_interconnect \
    -f tcb_interconnect_top.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "build error, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "Regression failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Regression passed" sim.log || { echo "simulation ended without a verdict"; exit 1; }
exit 0
